//--- hw/color_histogram.sv
// colour histogram with a two-stage saturating bin pipeline and a published bank
`include "stats_defs.svh"

module color_histogram (
    input  logic                           clock_in,
    input  logic                           rst_n,
    input  logic [`STATS_SAMPLE_WIDTH-1:0] sample,
    input  logic                           pixel_valid,
    input  logic                           publish,
    input  logic [`STATS_BIN_WIDTH-1:0]    bin_sel,
    output logic [`STATS_COUNT_WIDTH-1:0]  bin_count
);

    logic [`STATS_COUNT_WIDTH-1:0] work_bins [`STATS_NUM_BINS];
    logic [`STATS_COUNT_WIDTH-1:0] pub_bins  [`STATS_NUM_BINS];

    logic [`STATS_BIN_WIDTH-1:0]   in_bin;
    logic [`STATS_COUNT_WIDTH-1:0] in_count;

    logic                          s1_valid;
    logic [`STATS_BIN_WIDTH-1:0]   s1_bin;
    logic [`STATS_COUNT_WIDTH-1:0] s1_count;
    logic [`STATS_COUNT_WIDTH-1:0] s2_count;

    // each bin spans 128 codes, so the top bits are the index.
    assign in_bin = sample[`STATS_SAMPLE_WIDTH-1 -: `STATS_BIN_WIDTH];

    // stage 2 value, held at full scale.
    assign s2_count = (&s1_count) ? s1_count : s1_count + 1'b1;

    // the write to this bin lands at the end of this cycle, so take it early.
    assign in_count = (s1_valid && (s1_bin == in_bin)) ? s2_count : work_bins[in_bin];

    always_ff @(posedge clock_in or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s1_bin   <= '0;
            s1_count <= '0;
            for (int i = 0; i < `STATS_NUM_BINS; i++) begin
                work_bins[i] <= '0;
                pub_bins[i]  <= '0;
            end
        end else if (publish) begin
            s1_valid <= 1'b0;                      // nothing is in flight after the drain.
            for (int i = 0; i < `STATS_NUM_BINS; i++) begin
                pub_bins[i]  <= work_bins[i];
                work_bins[i] <= '0;
            end
        end else begin
            if (s1_valid) begin
                work_bins[s1_bin] <= s2_count;
            end
            s1_valid <= pixel_valid;
            s1_bin   <= in_bin;
            s1_count <= in_count;
        end
    end

    assign bin_count = pub_bins[bin_sel];

    // Bins only grow during a frame, which forwarding must preserve.
    for (genvar i = 0; i < `STATS_NUM_BINS; i++) begin : g_bin_check
        assert property (@(posedge clock_in) disable iff (!rst_n)
            !publish |=> (work_bins[i] >= $past(work_bins[i])))
            else $error("working bin %0d decreased outside publish.", i);
    end

endmodule

//--- hw/frame_sequencer.sv
// frame sequencer that follows frame_valid, drains the histogram pipeline and publishes results
module frame_sequencer (
    input  logic                  clock_in,
    input  logic                  rst_n,
    input  logic                  frame_valid,
    output logic                  publish,
    output logic                  histogram_ready,
    output stats_pkg::seq_state_e state
);

    logic frame_valid_q;
    logic frame_end;
    logic drain_cnt;

    assign frame_end   = frame_valid_q && !frame_valid;   // first cycle after the frame.
    assign publish     = (state == stats_pkg::seq_publish);

    always_ff @(posedge clock_in or negedge rst_n) begin
        if (!rst_n) begin
            frame_valid_q   <= 1'b0;
            state           <= stats_pkg::seq_idle;
            drain_cnt       <= 1'b0;
            histogram_ready <= 1'b0;
        end else begin
            frame_valid_q <= frame_valid;
            case (state)
                stats_pkg::seq_idle: begin
                    // A frame that rose during the drain is already high here.
                    if (frame_valid) begin
                        state           <= stats_pkg::seq_active;
                        histogram_ready <= 1'b0;
                    end
                end
                stats_pkg::seq_active: begin
                    if (frame_end) begin
                        state     <= stats_pkg::seq_drain;
                        drain_cnt <= 1'b0;
                    end
                end
                stats_pkg::seq_drain: begin
                    if (drain_cnt) begin
                        state     <= stats_pkg::seq_publish;  // second drain cycle done.
                        drain_cnt <= 1'b0;
                    end else begin
                        drain_cnt <= 1'b1;
                    end
                end
                stats_pkg::seq_publish: begin
                    state           <= stats_pkg::seq_idle;
                    histogram_ready <= 1'b1;                // results are now in the bank.
                end
                default: begin
                    state <= stats_pkg::seq_idle;
                end
            endcase
        end
    end

    // publish is a strobe, so the banks copy once per frame.
    assert property (@(posedge clock_in) disable iff (!rst_n) publish |=> !publish)
        else $error("publish held for more than one cycle.");

    // the host must never see ready while a frame is still being binned.
    assert property (@(posedge clock_in) disable iff (!rst_n)
        (state == stats_pkg::seq_active) |-> !histogram_ready)
        else $error("histogram_ready high during an active frame.");

endmodule

//--- hw/image_stats_top.sv
// image statistics top level joining the sequencer, counters, histograms and register slave
`include "stats_defs.svh"

module image_stats_top (
    input  logic               clock_in,
    input  logic               rst_n,
    input  stats_pkg::pixel_t  pixel,
    input  logic               line_valid,
    input  logic               frame_valid,
    input  stats_pkg::wb_req_t wb_req,
    output stats_pkg::wb_rsp_t wb_rsp,
    output logic               histogram_ready
);

    logic                                pixel_valid;
    logic                                publish;
    stats_pkg::seq_state_e               state;
    logic [`STATS_PIXEL_COUNT_WIDTH-1:0] pixel_count;
    logic [`STATS_FRAME_WIDTH-1:0]       frame_number;
    logic [`STATS_BIN_WIDTH-1:0]         bin_sel;
    logic [`STATS_COUNT_WIDTH-1:0]       red_count;
    logic [`STATS_COUNT_WIDTH-1:0]       green_count;
    logic [`STATS_COUNT_WIDTH-1:0]       blue_count;

    assign pixel_valid = frame_valid && line_valid;    // no back-pressure on the stream.

    frame_sequencer sequencer (
        .clock_in        (clock_in),
        .rst_n           (rst_n),
        .frame_valid     (frame_valid),
        .publish         (publish),
        .histogram_ready (histogram_ready),
        .state           (state)
    );

    pixel_counter counter (
        .clock_in     (clock_in),
        .rst_n        (rst_n),
        .pixel_valid  (pixel_valid),
        .publish      (publish),
        .pixel_count  (pixel_count),
        .frame_number (frame_number)
    );

    color_histogram red_hist (
        .clock_in    (clock_in),
        .rst_n       (rst_n),
        .sample      (pixel.red),
        .pixel_valid (pixel_valid),
        .publish     (publish),
        .bin_sel     (bin_sel),
        .bin_count   (red_count)
    );

    color_histogram green_hist (
        .clock_in    (clock_in),
        .rst_n       (rst_n),
        .sample      (pixel.green),
        .pixel_valid (pixel_valid),
        .publish     (publish),
        .bin_sel     (bin_sel),
        .bin_count   (green_count)
    );

    color_histogram blue_hist (
        .clock_in    (clock_in),
        .rst_n       (rst_n),
        .sample      (pixel.blue),
        .pixel_valid (pixel_valid),
        .publish     (publish),
        .bin_sel     (bin_sel),
        .bin_count   (blue_count)
    );

    stats_wb_regs regs (
        .clock_in        (clock_in),
        .rst_n           (rst_n),
        .wb_req          (wb_req),
        .wb_rsp          (wb_rsp),
        .bin_sel         (bin_sel),
        .red_count       (red_count),
        .green_count     (green_count),
        .blue_count      (blue_count),
        .pixel_count     (pixel_count),
        .frame_number    (frame_number),
        .histogram_ready (histogram_ready),
        .state           (state)
    );

endmodule

//--- hw/pixel_counter.sv
// pixel counter that counts valid pixels per frame and numbers the published frames
`include "stats_defs.svh"

module pixel_counter (
    input  logic                                clock_in,
    input  logic                                rst_n,
    input  logic                                pixel_valid,
    input  logic                                publish,
    output logic [`STATS_PIXEL_COUNT_WIDTH-1:0] pixel_count,
    output logic [`STATS_FRAME_WIDTH-1:0]       frame_number
);

    logic [`STATS_PIXEL_COUNT_WIDTH-1:0] running_count;
    logic                                running_full;

    assign running_full = &running_count;                  // count holds at all ones.

    always_ff @(posedge clock_in or negedge rst_n) begin
        if (!rst_n) begin
            running_count <= '0;
            pixel_count   <= '0;
            frame_number  <= '0;
        end else if (publish) begin
            // A pixel in the publish cycle belongs to no frame and is dropped.
            pixel_count   <= running_count;
            running_count <= '0;
            frame_number  <= frame_number + 1'b1;      // wraps after the last number.
        end else if (pixel_valid && !running_full) begin
            running_count <= running_count + 1'b1;
        end
    end

endmodule

//--- hw/stats_defs.svh
// image statistics shared sizes for the histogram bins, counters and the register map
`ifndef STATS_DEFS_SVH
`define STATS_DEFS_SVH

// number of brightness bins per colour channel.
`define STATS_NUM_BINS 8

// bits in a bin index, taken from the top of each sample.
`define STATS_BIN_WIDTH 3

// width of one saturating bin count.
`define STATS_COUNT_WIDTH 8

// width of one colour sample from the sensor.
`define STATS_SAMPLE_WIDTH 10

// width of the per-frame valid pixel count.
`define STATS_PIXEL_COUNT_WIDTH 16

// width of the frame number.
`define STATS_FRAME_WIDTH 8

// wishbone word address width.
`define STATS_ADDR_WIDTH 6

`endif

//--- hw/stats_pkg.sv
// image statistics types for the pixel bus, the wishbone port and the sequencer
`include "stats_defs.svh"

package stats_pkg;

    // one pixel of three colour samples.
    typedef struct packed {
        logic [`STATS_SAMPLE_WIDTH-1:0] red;
        logic [`STATS_SAMPLE_WIDTH-1:0] green;
        logic [`STATS_SAMPLE_WIDTH-1:0] blue;
    } pixel_t;

    // wishbone classic master to slave signals.
    typedef struct packed {
        logic                         cyc;
        logic                         stb;
        logic                         we;
        logic [`STATS_ADDR_WIDTH-1:0] adr;
        logic [31:0]                  dat_w;
    } wb_req_t;

    // wishbone classic slave to master signals.
    typedef struct packed {
        logic        ack;
        logic [31:0] dat_r;
    } wb_rsp_t;

    // address seen as a histogram location.
    typedef struct packed {
        logic                        region;  // zero selects the histograms.
        logic [1:0]                  channel; // red, green, blue in that order.
        logic [`STATS_BIN_WIDTH-1:0] bin;
    } wb_hist_addr_t;

    // address seen as a status register index.
    typedef struct packed {
        logic       region;                   // one selects the status words.
        logic [1:0] spare;
        logic [2:0] index;
    } wb_status_addr_t;

    // The same word address is decoded either way, depending on its top bit.
    typedef union packed {
        wb_hist_addr_t   hist;
        wb_status_addr_t status;
    } wb_addr_u;

    // frame sequencer states, also visible in the status word.
    typedef enum logic [1:0] {
        seq_idle    = 2'd0,
        seq_active  = 2'd1,
        seq_drain   = 2'd2,
        seq_publish = 2'd3
    } seq_state_e;

endpackage

//--- hw/stats_wb_regs.sv
// wishbone classic slave that returns published bins and status words to the host
`include "stats_defs.svh"

module stats_wb_regs (
    input  logic                                clock_in,
    input  logic                                rst_n,
    input  stats_pkg::wb_req_t                  wb_req,
    output stats_pkg::wb_rsp_t                  wb_rsp,
    output logic [`STATS_BIN_WIDTH-1:0]         bin_sel,
    input  logic [`STATS_COUNT_WIDTH-1:0]       red_count,
    input  logic [`STATS_COUNT_WIDTH-1:0]       green_count,
    input  logic [`STATS_COUNT_WIDTH-1:0]       blue_count,
    input  logic [`STATS_PIXEL_COUNT_WIDTH-1:0] pixel_count,
    input  logic [`STATS_FRAME_WIDTH-1:0]       frame_number,
    input  logic                                histogram_ready,
    input  stats_pkg::seq_state_e               state
);

    stats_pkg::wb_addr_u addr;
    logic                request;
    logic                ack_q;
    logic [31:0]         read_word;
    logic [31:0]         dat_r_q;

    assign addr    = wb_req.adr;
    assign request = wb_req.cyc && wb_req.stb;
    assign bin_sel = addr.hist.bin;                    // drives all three bank muxes.

    always_comb begin
        read_word = '0;
        if (!addr.hist.region) begin
            case (addr.hist.channel)
                2'd0:    read_word = 32'(red_count);
                2'd1:    read_word = 32'(green_count);
                2'd2:    read_word = 32'(blue_count);
                default: read_word = '0;
            endcase
        end else if (addr.status.spare == 2'b00) begin
            case (addr.status.index)
                3'd0:    read_word = 32'({state, histogram_ready});
                3'd1:    read_word = 32'(pixel_count);
                3'd2:    read_word = 32'(frame_number);
                default: read_word = '0;
            endcase
        end
    end

    // one ack per request, then a quiet cycle.
    always_ff @(posedge clock_in or negedge rst_n) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= request && !ack_q;
        end
    end

    always_ff @(posedge clock_in) begin
        if (request && !ack_q) begin
            dat_r_q <= wb_req.we ? 32'd0 : read_word;  // writes change nothing.
        end
    end

    assign wb_rsp.ack   = ack_q;
    assign wb_rsp.dat_r = dat_r_q;

    // the master holds its strobe until ack, so an ack always meets a live cycle.
    assert property (@(posedge clock_in) disable iff (!rst_n)
        wb_rsp.ack |-> (wb_req.cyc && wb_req.stb))
        else $error("ack raised without cyc and stb.");

endmodule

//--- run_sim.sh
#!/bin/sh
# Builds the image statistics testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f sim.f --top-module image_stats_tb \
    -o image_stats_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/image_stats_sim > sim.log 2>&1 || echo "Testbench failed" >> sim.log
cat sim.log
grep -q "Testbench failed" sim.log && exit 1 || exit 0

//--- sim.f
+incdir+hw
hw/stats_pkg.sv
hw/frame_sequencer.sv
hw/pixel_counter.sv
hw/color_histogram.sv
hw/stats_wb_regs.sv
hw/image_stats_top.sv
testbench/image_stats_tb.sv

//--- testbench/image_stats_tb.sv
// testbench for the image statistics block, driven by frame records read from a data file
`include "stats_defs.svh"

module image_stats_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES  = 4;
    localparam int FRAME_BUDGET  = 200;
    localparam int MAX_EXTRA_GAP = 3;

    logic               clock_in;
    logic               rst_n;
    stats_pkg::pixel_t  pixel;
    logic               line_valid;
    logic               frame_valid;
    stats_pkg::wb_req_t wb_req;
    stats_pkg::wb_rsp_t wb_rsp;
    logic               histogram_ready;

    int     cycle_count;
    int     cycle_limit;
    integer seed;
    bit     in_frame;
    string  test_name;
    int     exp_bins [3][`STATS_NUM_BINS];
    int     last_pixel_count;
    int     last_frame;

    image_stats_top dut (
        .clock_in        (clock_in),
        .rst_n           (rst_n),
        .pixel           (pixel),
        .line_valid      (line_valid),
        .frame_valid     (frame_valid),
        .wb_req          (wb_req),
        .wb_rsp          (wb_rsp),
        .histogram_ready (histogram_ready)
    );

    initial begin
        clock_in = 1'b0;
        forever begin
            #10 clock_in = ~clock_in;
        end
    end

    // the limit grows as records are read, so a stuck DUT ends the run.
    always @(posedge clock_in) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("ERROR: the DUT made no progress within %0d cycles.", cycle_limit);
            $display("Testbench failed");
            $fatal(1, "timeout");
        end
    end

    task automatic next_cycle();
        @(posedge clock_in);
        #2;                                                // inputs change away from the edge.
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s expected 0x%0h actual 0x%0h", name, expected, actual);
            $display("Testbench failed");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic wb_access(input logic write, input logic [5:0] adr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        wb_req.cyc   = 1'b1;
        wb_req.stb   = 1'b1;
        wb_req.we    = write;
        wb_req.adr   = adr;
        wb_req.dat_w = wdata;
        do begin
            next_cycle();
        end while (!wb_rsp.ack);
        rdata = wb_rsp.dat_r;
        next_cycle();                                      // stb is still up on the edge that sees ack.
        wb_req = '0;
    endtask

    task automatic expect_read(input logic [5:0] adr, input logic [31:0] expected);
        logic [31:0] data;
        wb_access(1'b0, adr, 32'd0, data);
        check($sformatf("%s adr %0d", test_name, adr), expected, data);
    endtask

    // status words sit at 32 and up, the bins at channel * 8 + bin.
    task automatic verify_readout(input int status, input int pcount, input int fnum);
        expect_read(6'd32, 32'(status));
        expect_read(6'd33, 32'(pcount));
        expect_read(6'd34, 32'(fnum));
        for (int c = 0; c < 3; c++) begin
            for (int b = 0; b < `STATS_NUM_BINS; b++) begin
                expect_read(6'(c * 8 + b), 32'(exp_bins[c][b]));
            end
        end
    endtask

    task automatic start_frame();
        frame_valid = 1'b1;
        line_valid  = 1'b0;
        cycle_limit = cycle_limit + 2;
        next_cycle();
        next_cycle();
        check({test_name, " ready at frame start"}, 32'd0, 32'(histogram_ready));
        in_frame = 1'b1;
    endtask

    task automatic drive_pixels(input int count, input int r, input int g, input int b);
        pixel.red   = 10'(r);
        pixel.green = 10'(g);
        pixel.blue  = 10'(b);
        line_valid  = 1'b1;
        repeat (count) next_cycle();
    endtask

    task automatic idle_cycles(input int count);
        line_valid = 1'b0;                                 // frame_valid stays high in a gap.
        repeat (count) next_cycle();
    endtask

    task automatic end_frame(input int pcount, input int fnum);
        line_valid  = 1'b0;
        frame_valid = 1'b0;
        in_frame    = 1'b0;
        cycle_limit = cycle_limit + FRAME_BUDGET;
        while (!histogram_ready) begin
            next_cycle();
        end
        verify_readout(1, pcount, fnum);                   // ready set with the sequencer idle.
        last_pixel_count = pcount;
        last_frame       = fnum;
    endtask

    initial begin
        int          fd;
        int          code;
        int          extra;
        int          vals [9];
        string       line;
        string       kind;
        logic [31:0] data;

        rst_n       = 1'b0;
        pixel       = '0;
        line_valid  = 1'b0;
        frame_valid = 1'b0;
        wb_req      = '0;
        in_frame    = 1'b0;
        seed        = 32'h06608cf6;
        cycle_count = 0;
        cycle_limit = RESET_CYCLES + FRAME_BUDGET;
        foreach (exp_bins[c, b]) exp_bins[c][b] = 0;
        repeat (RESET_CYCLES) @(posedge clock_in);
        #2;
        rst_n = 1'b1;

        test_name = "after_reset";
        check({test_name, " ready"}, 32'd0, 32'(histogram_ready));
        verify_readout(0, 0, 0);

        fd = $fopen("testbench/stats_input.txt", "r");
        if (fd == 0) begin
            $display("ERROR: the stimulus file testbench/stats_input.txt could not be opened.");
            $display("Testbench failed");
            $fatal(1, "no stimulus");
        end
        while (!$feof(fd)) begin
            line = "";
            kind = "";
            code = $fgets(line, fd);
            code = $sscanf(line, "%s", kind);
            if (kind == "T") begin
                code = $sscanf(line, "%s %s", kind, test_name);
            end else if (kind == "P" || kind == "R") begin
                if (kind == "P") begin
                    vals[0] = 1;
                    code = $sscanf(line, "%s %h %h %h", kind, vals[1], vals[2], vals[3]);
                end else begin
                    code = $sscanf(line, "%s %d %h %h %h", kind, vals[0], vals[1], vals[2],
                                   vals[3]);
                end
                if (!in_frame) start_frame();
                cycle_limit = cycle_limit + vals[0];
                drive_pixels(vals[0], vals[1], vals[2], vals[3]);
            end else if (kind == "G") begin
                code  = $sscanf(line, "%s %d", kind, vals[0]);
                extra = $unsigned($random(seed)) % (MAX_EXTRA_GAP + 1);
                if (!in_frame) start_frame();
                cycle_limit = cycle_limit + vals[0] + extra;
                idle_cycles(vals[0] + extra);
            end else if (kind == "C") begin
                code = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d", kind, vals[0], vals[1],
                               vals[2], vals[3], vals[4], vals[5], vals[6], vals[7], vals[8]);
                for (int b = 0; b < `STATS_NUM_BINS; b++) begin
                    exp_bins[vals[0]][b] = vals[b + 1];
                end
            end else if (kind == "E") begin
                code = $sscanf(line, "%s %d %d", kind, vals[0], vals[1]);
                end_frame(vals[0], vals[1]);
            end else if (kind != "" && kind != "#") begin
                $display("ERROR: the stimulus file holds an unknown record: %s", line);
                $display("Testbench failed");
                $fatal(1, "bad record");
            end
        end
        $fclose(fd);

        // spare status indices, then writes that must leave the readout alone.
        test_name   = "status_and_write";
        cycle_limit = cycle_limit + FRAME_BUDGET;
        for (int i = 3; i < 8; i++) begin
            expect_read(6'(32 + i), 32'd0);
        end
        wb_access(1'b1, 6'd33, 32'hffff_ffff, data);
        wb_access(1'b1, 6'd5, 32'h0000_00ff, data);
        verify_readout(1, last_pixel_count, last_frame);

        $display("Testbench passed");
        $finish;
    end

endmodule

//--- testbench/stats_input.txt
# records: T name | P r g b (hex samples) | R count r g b | G idle_cycles (frame stays high)
# C channel bin0 .. bin7 (expected counts, decimal) | E pixel_count frame_number ends the frame
T mixed_values
P 07f 080 3ff
P 080 07f 000
P 3ff 3ff 3ff
G 3
P 200 100 180
P 37f 27f 17f
G 2
R 5 000 3ff 080
C 0 6 1 0 0 1 0 1 1
C 1 1 1 1 0 1 0 0 6
C 2 1 5 1 1 0 0 0 2
E 10 1
T saturation
R 300 2a5 155 0ff
C 0 0 0 0 0 0 255 0 0
C 1 0 0 255 0 0 0 0 0
C 2 0 255 0 0 0 0 0 0
E 300 2
T forwarding
P 000 3ff 200
P 000 3ff 280
P 000 000 200
P 080 3ff 280
P 000 000 200
P 080 3ff 200
P 080 3ff 280
P 000 000 280
R 4 100 100 100
C 0 5 3 4 0 0 0 0 0
C 1 3 0 4 0 0 0 0 5
C 2 0 0 4 0 4 4 0 0
E 12 3
